//--- Makefile
# Verilator build and run for the fetch front end

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TOP       ?= tb_fetch_top
RTL_TOP   ?= fetch_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/bp_lookup_if.sv
`timescale 1ns/1ps

// Fetch address out to the predictor, prediction back
interface bp_lookup_if;
    bp_pkg::addr_t pc;
    logic hit;
    logic taken;
    bp_pkg::addr_t target;

    modport sequencer (
        output pc,
        input  hit,
        input  taken,
        input  target
    );

    modport predictor (
        input  pc,
        output hit,
        output taken,
        output target
    );
endinterface

//--- common/bp_pkg.sv
package bp_pkg;

    // Sizing
    localparam int ADDR_WIDTH = 32;
    localparam int INDEX_BITS = 4;
    localparam int ENTRIES = 1 << INDEX_BITS;
    localparam int BYTE_BITS = 2;
    localparam int TAG_BITS = ADDR_WIDTH - INDEX_BITS - BYTE_BITS;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0] tag_t;

    localparam addr_t RESET_PC = '0;
    localparam addr_t INSTR_BYTES = addr_t'(4);

    // Two-bit saturating direction counter
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } counter_t;

    function automatic index_t pc_index(addr_t pc);
        return pc[INDEX_BITS+BYTE_BITS-1:BYTE_BITS];
    endfunction

    function automatic tag_t pc_tag(addr_t pc);
        return pc[ADDR_WIDTH-1:INDEX_BITS+BYTE_BITS];
    endfunction

    function automatic logic is_taken(counter_t count);
        return (count == WEAK_T) || (count == STRONG_T);
    endfunction

endpackage

//--- common/bp_update_if.sv
`timescale 1ns/1ps

// Training write from the resolver
// Single-cycle strobe with no acknowledge
interface bp_update_if;
    logic valid;
    bp_pkg::addr_t pc;
    logic taken;
    bp_pkg::addr_t target;

    modport resolver (
        output valid,
        output pc,
        output taken,
        output target
    );

    modport predictor (
        input valid,
        input pc,
        input taken,
        input target
    );
endinterface

//--- filelist.f
common/bp_pkg.sv
common/bp_lookup_if.sv
common/bp_update_if.sv
predictor/branch_predictor.sv
source/pc_sequencer.sv
source/branch_resolver.sv
source/fetch_top.sv
tests/tb_fetch_top.sv

//--- predictor/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor (
    input  logic clk,
    input  logic reset,
    bp_lookup_if.predictor lookup,
    bp_update_if.predictor update
);

    // Table storage
    logic valid_q [bp_pkg::ENTRIES];
    bp_pkg::tag_t tag_q [bp_pkg::ENTRIES];
    bp_pkg::addr_t target_q [bp_pkg::ENTRIES];
    bp_pkg::counter_t counter_q [bp_pkg::ENTRIES];

    bp_pkg::index_t look_idx;
    logic look_valid;

    bp_pkg::index_t upd_idx;
    bp_pkg::tag_t upd_tag;
    bp_pkg::counter_t base_count;
    bp_pkg::counter_t next_count;

    // Lookup path in the same cycle as the fetch address
    assign look_idx = bp_pkg::pc_index(lookup.pc);
    assign look_valid = valid_q[look_idx];

    assign lookup.hit = look_valid && (tag_q[look_idx] == bp_pkg::pc_tag(lookup.pc));
    assign lookup.taken = lookup.hit && bp_pkg::is_taken(counter_q[look_idx]);
    assign lookup.target = look_valid ? target_q[look_idx] : '0;

    assign upd_idx = bp_pkg::pc_index(update.pc);
    assign upd_tag = bp_pkg::pc_tag(update.pc);

    // A new or replaced branch counts from weak not-taken
    always_comb begin
        if (!valid_q[upd_idx] || (tag_q[upd_idx] != upd_tag)) begin
            base_count = bp_pkg::WEAK_NT;
        end else begin
            base_count = counter_q[upd_idx];
        end
    end

    // One saturating step in the resolved direction
    always_comb begin
        case (base_count)
            bp_pkg::STRONG_NT: next_count = update.taken ? bp_pkg::WEAK_NT : bp_pkg::STRONG_NT;
            bp_pkg::WEAK_NT:   next_count = update.taken ? bp_pkg::WEAK_T : bp_pkg::STRONG_NT;
            bp_pkg::WEAK_T:    next_count = update.taken ? bp_pkg::STRONG_T : bp_pkg::WEAK_NT;
            default:           next_count = update.taken ? bp_pkg::STRONG_T : bp_pkg::WEAK_T;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < bp_pkg::ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
                counter_q[i] <= bp_pkg::WEAK_NT;
            end
        end else if (update.valid) begin
            valid_q[upd_idx] <= 1'b1;
            counter_q[upd_idx] <= next_count;
        end
    end

    // Entry tag and target
    always_ff @(posedge clk) begin
        if (update.valid) begin
            tag_q[upd_idx] <= upd_tag;
            target_q[upd_idx] <= update.target;
        end
    end

    // Training writes must come from word-aligned branches
    update_pc_aligned: assert property (
        @(posedge clk) disable iff (reset)
        update.valid |-> (update.pc[1:0] == 2'b00)
    ) else $error("branch_predictor: misaligned update pc %h", update.pc);

endmodule

//--- source/branch_resolver.sv
`timescale 1ns/1ps

module branch_resolver (
    input  logic resolve_valid,
    input  bp_pkg::addr_t resolve_pc,
    input  logic resolve_taken,
    input  bp_pkg::addr_t resolve_target,
    input  logic resolve_pred_taken,
    input  bp_pkg::addr_t resolve_pred_target,
    output logic flush,
    output bp_pkg::addr_t flush_pc,
    bp_update_if.resolver update
);

    logic dir_wrong;
    logic target_wrong;

    // Wrong direction, or taken both ways but to another place
    assign dir_wrong = resolve_taken != resolve_pred_taken;
    assign target_wrong = resolve_taken && resolve_pred_taken &&
                          (resolve_target != resolve_pred_target);

    assign flush = resolve_valid && (dir_wrong || target_wrong);
    assign flush_pc = resolve_taken ? resolve_target : resolve_pc + bp_pkg::INSTR_BYTES;

    // Every resolved branch trains the table
    assign update.valid = resolve_valid;
    assign update.pc = resolve_pc;
    assign update.taken = resolve_taken;
    assign update.target = resolve_target;

    // Resolved branches sit on word boundaries
    always_comb begin
        if (resolve_valid) begin
            resolve_pc_aligned: assert final (resolve_pc[1:0] == 2'b00)
                else $error("branch_resolver: misaligned resolve pc %h", resolve_pc);
        end
    end

endmodule

//--- source/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  logic resolve_valid,
    input  bp_pkg::addr_t resolve_pc,
    input  logic resolve_taken,
    input  bp_pkg::addr_t resolve_target,
    input  logic resolve_pred_taken,
    input  bp_pkg::addr_t resolve_pred_target,
    output bp_pkg::addr_t fetch_pc,
    output logic pred_hit,
    output logic pred_taken,
    output bp_pkg::addr_t pred_target,
    output logic flush
);

    bp_lookup_if lookup_bus ();
    bp_update_if update_bus ();

    bp_pkg::addr_t flush_pc;

    branch_predictor u_predictor (
        .clk    (clk),
        .reset  (reset),
        .lookup (lookup_bus),
        .update (update_bus)
    );

    pc_sequencer u_sequencer (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .flush    (flush),
        .flush_pc (flush_pc),
        .lookup   (lookup_bus),
        .fetch_pc (fetch_pc)
    );

    branch_resolver u_resolver (
        .resolve_valid       (resolve_valid),
        .resolve_pc          (resolve_pc),
        .resolve_taken       (resolve_taken),
        .resolve_target      (resolve_target),
        .resolve_pred_taken  (resolve_pred_taken),
        .resolve_pred_target (resolve_pred_target),
        .flush               (flush),
        .flush_pc            (flush_pc),
        .update              (update_bus)
    );

    // Prediction for the current fetch address
    assign pred_hit = lookup_bus.hit;
    assign pred_taken = lookup_bus.taken;
    assign pred_target = lookup_bus.target;

endmodule

//--- source/pc_sequencer.sv
`timescale 1ns/1ps

module pc_sequencer (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  logic flush,
    input  bp_pkg::addr_t flush_pc,
    bp_lookup_if.sequencer lookup,
    output bp_pkg::addr_t fetch_pc
);

    bp_pkg::addr_t next_pc;

    assign lookup.pc = fetch_pc;

    // Redirect wins over stall, stall over prediction
    always_comb begin
        if (flush) begin
            next_pc = flush_pc;
        end else if (stall) begin
            next_pc = fetch_pc;
        end else if (lookup.taken) begin
            next_pc = lookup.target;
        end else begin
            next_pc = fetch_pc + bp_pkg::INSTR_BYTES;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc <= bp_pkg::RESET_PC;
        end else begin
            fetch_pc <= next_pc;
        end
    end

    // Targets from the table and from execute keep fetch aligned
    fetch_pc_aligned: assert property (
        @(posedge clk) disable iff (reset)
        fetch_pc[1:0] == 2'b00
    ) else $error("pc_sequencer: misaligned fetch pc %h", fetch_pc);

endmodule

//--- tests/fetch_stimulus.txt
# inputs:  stall resolve_valid resolve_pc resolve_taken resolve_target pred_taken pred_target
# expected: fetch_pc pred_hit pred_taken pred_target flush (one line per cycle, all hex)
0 1 00000014 1 00000080 1 00000080 00000000 0 0 00000000 0
0 1 00000014 1 00000080 1 00000080 00000004 0 0 00000000 0
1 0 00000000 0 00000000 0 00000000 00000008 0 0 00000000 0
1 0 00000000 0 00000000 0 00000000 00000008 0 0 00000000 0
0 0 00000000 0 00000000 0 00000000 00000008 0 0 00000000 0
0 0 00000000 0 00000000 0 00000000 0000000c 0 0 00000000 0
0 0 00000000 0 00000000 0 00000000 00000010 0 0 00000000 0
0 0 00000000 0 00000000 0 00000000 00000014 1 1 00000080 0
0 1 0000008c 0 000000c0 0 00000000 00000080 0 0 00000000 0
0 1 0000008c 0 000000c0 0 00000000 00000084 0 0 00000000 0
0 1 0000008c 0 000000c0 0 00000000 00000088 0 0 00000000 0
1 1 0000008c 1 000000c0 1 000000c0 0000008c 1 0 000000c0 0
0 1 00000054 1 00000100 1 00000100 0000008c 1 0 000000c0 0
1 1 00000200 1 00000014 0 00000000 00000090 0 0 00000000 1
0 0 00000000 0 00000000 0 00000000 00000014 0 0 00000100 0
0 1 00000300 1 00000040 1 00000044 00000018 0 0 00000000 1
1 1 00000044 0 00000080 1 00000080 00000040 0 0 00000040 1
0 1 00000048 0 00000060 0 00000000 00000048 0 0 00000000 0
0 0 00000000 0 00000000 0 00000000 0000004c 0 0 000000c0 0
0 0 00000000 0 00000000 0 00000000 00000050 0 0 00000000 0
0 0 00000000 0 00000000 0 00000000 00000054 1 1 00000100 0
0 0 00000000 0 00000000 0 00000000 00000100 0 0 00000040 0
1 0 00000000 0 00000000 0 00000000 00000104 0 0 00000080 0
0 0 00000000 0 00000000 0 00000000 00000104 0 0 00000080 0
0 0 00000000 0 00000000 0 00000000 00000108 0 0 00000060 0

//--- tests/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 2;
    localparam int MARGIN_CYCLES = 20;
    localparam string STIMULUS_PATH = "tests/fetch_stimulus.txt";

    // One cycle of stimulus and the outputs expected during that cycle
    typedef struct packed {
        logic stall;
        logic resolve_valid;
        bp_pkg::addr_t resolve_pc;
        logic resolve_taken;
        bp_pkg::addr_t resolve_target;
        logic resolve_pred_taken;
        bp_pkg::addr_t resolve_pred_target;
        bp_pkg::addr_t fetch_pc;
        logic pred_hit;
        logic pred_taken;
        bp_pkg::addr_t pred_target;
        logic flush;
    } vector_t;

    logic clk;
    logic reset;
    logic stall;
    logic resolve_valid;
    bp_pkg::addr_t resolve_pc;
    logic resolve_taken;
    bp_pkg::addr_t resolve_target;
    logic resolve_pred_taken;
    bp_pkg::addr_t resolve_pred_target;
    bp_pkg::addr_t fetch_pc;
    logic pred_hit;
    logic pred_taken;
    bp_pkg::addr_t pred_target;
    logic flush;

    vector_t vectors [$];
    logic vectors_loaded = 1'b0;
    int error_count = 0;

    fetch_top DUT (
        .clk                 (clk),
        .reset               (reset),
        .stall               (stall),
        .resolve_valid       (resolve_valid),
        .resolve_pc          (resolve_pc),
        .resolve_taken       (resolve_taken),
        .resolve_target      (resolve_target),
        .resolve_pred_taken  (resolve_pred_taken),
        .resolve_pred_target (resolve_pred_target),
        .fetch_pc            (fetch_pc),
        .pred_hit            (pred_hit),
        .pred_taken          (pred_taken),
        .pred_target         (pred_target),
        .flush               (flush)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic load_vectors();
        int fd;
        int fields;
        string line;
        logic [31:0] col [12];
        vector_t v;
        fd = $fopen(STIMULUS_PATH, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", STIMULUS_PATH);
            error_count++;
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) begin
                break;
            end
            // Header lines start with a hash
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                             col[0], col[1], col[2], col[3], col[4], col[5],
                             col[6], col[7], col[8], col[9], col[10], col[11]);
            if (fields == 12) begin
                v.stall = col[0][0];
                v.resolve_valid = col[1][0];
                v.resolve_pc = col[2];
                v.resolve_taken = col[3][0];
                v.resolve_target = col[4];
                v.resolve_pred_taken = col[5][0];
                v.resolve_pred_target = col[6];
                v.fetch_pc = col[7];
                v.pred_hit = col[8][0];
                v.pred_taken = col[9][0];
                v.pred_target = col[10];
                v.flush = col[11][0];
                vectors.push_back(v);
            end else if (fields > 0) begin
                $display("Malformed line in the stimulus file: %s", line);
                error_count++;
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_vector(input vector_t v);
        stall <= v.stall;
        resolve_valid <= v.resolve_valid;
        resolve_pc <= v.resolve_pc;
        resolve_taken <= v.resolve_taken;
        resolve_target <= v.resolve_target;
        resolve_pred_taken <= v.resolve_pred_taken;
        resolve_pred_target <= v.resolve_pred_target;
    endtask

    task automatic check_value(input string name, input int vec,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected)
        else begin
            error_count++;
            $display("FAILED %s at vector %0d: expected %0h, actual %0h",
                     name, vec, expected, actual);
        end
    endtask

    task automatic check_outputs(input vector_t v, input int vec);
        check_value("fetch_pc", vec, v.fetch_pc, fetch_pc);
        check_value("pred_hit", vec, 32'(v.pred_hit), 32'(pred_hit));
        check_value("pred_taken", vec, 32'(v.pred_taken), 32'(pred_taken));
        check_value("pred_target", vec, v.pred_target, pred_target);
        check_value("flush", vec, 32'(v.flush), 32'(flush));
    endtask

    initial begin
        reset = 1'b1;
        stall = 1'b0;
        resolve_valid = 1'b0;
        resolve_pc = '0;
        resolve_taken = 1'b0;
        resolve_target = '0;
        resolve_pred_taken = 1'b0;
        resolve_pred_target = '0;

        load_vectors();
        if (vectors.size() == 0) begin
            $display("No stimulus vectors were read");
            error_count++;
        end
        vectors_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // Drive on the rising edge, check once everything has settled
        foreach (vectors[i]) begin
            apply_vector(vectors[i]);
            @(negedge clk);
            check_outputs(vectors[i], i);
            @(posedge clk);
        end

        $display("Checked %0d vectors, %0d errors", vectors.size(), error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the number of vectors
    initial begin
        wait (vectors_loaded);
        #((vectors.size() + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the stimulus did not finish in the expected time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
